// File: flash_pkg.sv
`default_nettype none

package flash_pkg;

  // Bus window that maps onto flash words.
  localparam logic [15:0] flash_window_base = 16'h8000;
  localparam logic [15:0] flash_window_len  = 16'h8000;

  // Register map.
  localparam logic [15:0] reg_status_a      = 16'h0100;
  localparam logic [15:0] reg_dirty_page_a  = 16'h0101;
  localparam logic [15:0] reg_page_status_a = 16'h0102;
  localparam logic [15:0] reg_count_base_a  = 16'h0110;

  localparam int counter_count = 8;

  typedef enum logic [2:0] {
    kind_none,
    kind_reg_read,
    kind_reg_write,
    kind_flash_read,
    kind_flash_write,
    kind_status_read
  } access_kind_t;

  // Debug counter indices, in register order.
  typedef enum logic [2:0] {
    cnt_write,
    cnt_read,
    cnt_program,
    cnt_write_fail,
    cnt_read_fail,
    cnt_program_fail,
    cnt_read_trans,
    cnt_write_trans
  } counter_t;

  localparam logic [1:0]  fm_status_ok  = 2'b00;
  localparam logic [15:0] no_dirty_page = 16'hffff;

endpackage

`default_nettype wire

// File: flash_ifs.sv
`default_nettype none

interface flash_req_if import flash_pkg::*; ();
  access_kind_t kind;
  logic [2:0]   reg_sel;
  logic [15:0]  word_addr;
  logic [15:0]  data;
  logic         valid;
  logic         busy;
  logic         intrude;

  modport decoder (output kind, reg_sel, word_addr, data, valid, intrude, input busy);
  modport sequencer (input kind, reg_sel, word_addr, data, valid, intrude, output busy);
endinterface

interface flash_event_if ();
  logic ev_write;
  logic ev_read;
  logic ev_program;
  logic ev_write_fail;
  logic ev_read_fail;
  logic ev_program_fail;
  logic ev_read_trans;
  logic ev_write_trans;

  modport source (output ev_write, ev_read, ev_program, ev_write_fail, ev_read_fail,
                  ev_program_fail, ev_read_trans, ev_write_trans);
  modport sink (input ev_write, ev_read, ev_program, ev_write_fail, ev_read_fail,
                ev_program_fail, ev_read_trans, ev_write_trans);
endinterface

`default_nettype wire

// File: lb_decode.sv
`default_nettype none

module lb_decode import flash_pkg::*; (
  input  wire          lb_clk,
  input  wire          hard_reset,
  input  wire [15:0]   lb_addr,
  input  wire [15:0]   lb_data_in,
  input  wire          lb_rd,
  input  wire          lb_wr,
  input  wire          fm_busy,
  flash_req_if.decoder req
);

  logic [15:0]  offset;
  logic         in_window;
  logic         in_counters;
  logic         in_regs;
  logic         to_flash;
  access_kind_t next_kind;
  logic         held_rd;
  logic         held_wr;
  logic [15:0]  held_addr;

  assign offset      = lb_addr - flash_window_base;
  assign in_window   = (lb_addr >= flash_window_base) && (offset < flash_window_len);
  assign in_counters = (lb_addr >= reg_count_base_a) &&
                       (lb_addr < reg_count_base_a + 16'(counter_count));
  assign in_regs     = in_counters || (lb_addr == reg_status_a) ||
                       (lb_addr == reg_dirty_page_a) || (lb_addr == reg_page_status_a);

  always_comb begin
    next_kind = kind_none;
    if (lb_rd) begin
      if (lb_addr == reg_page_status_a)
        next_kind = kind_status_read;
      else if (in_regs)
        next_kind = kind_reg_read;
      else if (in_window)
        next_kind = kind_flash_read;
    end else if (lb_wr) begin
      if (in_regs)
        next_kind = kind_reg_write;
      else if (in_window)
        next_kind = kind_flash_write;
    end
  end

  // Anything touching the device waits out its busy.
  assign to_flash = next_kind inside {kind_flash_read, kind_flash_write, kind_status_read};

  // A held access is not an intrusion, a changed one is.
  assign req.intrude = req.busy && (lb_rd || lb_wr) &&
                       ((lb_rd != held_rd) || (lb_wr != held_wr) || (lb_addr != held_addr));

  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= !req.busy && (next_kind != kind_none) && !(to_flash && fm_busy);
    end
  end

  always_ff @(posedge lb_clk) begin
    if (!req.busy) begin
      req.kind      <= next_kind;
      req.reg_sel   <= 3'(lb_addr - reg_count_base_a);
      req.word_addr <= in_window ? offset : lb_addr;
      req.data      <= lb_data_in;
      held_rd       <= lb_rd;
      held_wr       <= lb_wr;
      held_addr     <= lb_addr;
    end
  end

endmodule

`default_nettype wire

// File: flash_sequencer.sv
`default_nettype none

module flash_sequencer import flash_pkg::*; #(
  parameter int fm_addr_width = 17,
  parameter int page_bits     = 6
) (
  input  wire                      lb_clk,
  input  wire                      hard_reset,
  flash_req_if.sequencer           req,
  flash_event_if.source            ev,
  input  wire [15:0]               count_value,
  output logic [fm_addr_width-1:0] fm_addr,
  output logic [15:0]              fm_wd,
  output logic                     fm_ren,
  output logic                     fm_wen,
  output logic                     fm_program,
  output logic                     fm_pagestatus,
  input  wire [15:0]               fm_rd,
  input  wire                      fm_busy,
  input  wire [1:0]                fm_status,
  output logic                     reply_valid,
  output logic [15:0]              reply_data,
  output logic                     reply_fail
);

  localparam int page_w = 16 - page_bits;

  typedef enum logic [2:0] {st_idle, st_program, st_read, st_write, st_clean} state_t;

  state_t            state;
  logic              dirty;
  logic [page_w-1:0] dirty_page;
  logic [page_w-1:0] req_page;
  logic [15:0]       pend_addr;
  logic              pend_write;
  logic [15:0]       pstat_addr;
  logic [2:0]        last_status;
  logic              wait_cycle;
  logic              lb_failure;
  logic              done;
  logic              status_ok;

  assign req.busy  = req.valid || (state != st_idle);
  assign req_page  = req.word_addr[15:page_bits];
  // First cycle after a command is skipped.
  assign done      = wait_cycle && !fm_busy;
  assign status_ok = fm_status == fm_status_ok;

  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      state              <= st_idle;
      fm_ren             <= 1'b0;
      fm_wen             <= 1'b0;
      fm_program         <= 1'b0;
      fm_pagestatus      <= 1'b0;
      dirty              <= 1'b0;
      last_status        <= 3'b111;
      wait_cycle         <= 1'b0;
      lb_failure         <= 1'b0;
      reply_valid        <= 1'b0;
      ev.ev_write        <= 1'b0;
      ev.ev_read         <= 1'b0;
      ev.ev_program      <= 1'b0;
      ev.ev_write_fail   <= 1'b0;
      ev.ev_read_fail    <= 1'b0;
      ev.ev_program_fail <= 1'b0;
      ev.ev_read_trans   <= 1'b0;
      ev.ev_write_trans  <= 1'b0;
    end else begin
      ev.ev_write        <= 1'b0;
      ev.ev_read         <= 1'b0;
      ev.ev_program      <= 1'b0;
      ev.ev_write_fail   <= 1'b0;
      ev.ev_read_fail    <= 1'b0;
      ev.ev_program_fail <= 1'b0;
      ev.ev_read_trans   <= 1'b0;
      ev.ev_write_trans  <= 1'b0;
      case (state)
        st_idle: begin
          wait_cycle <= 1'b0;
          lb_failure <= 1'b0;
          if (req.valid) begin
            case (req.kind)
              kind_reg_read: begin
                state       <= st_clean;
                reply_valid <= 1'b1;
                reply_fail  <= 1'b0;
                if (req.word_addr == reg_status_a)
                  reply_data <= {fm_busy, 12'd0, last_status};
                else if (req.word_addr == reg_dirty_page_a)
                  reply_data <= dirty ? 16'(dirty_page) : no_dirty_page;
                else
                  reply_data <= count_value;
              end
              kind_reg_write: begin
                if (req.word_addr == reg_page_status_a)
                  pstat_addr <= req.data;
                state       <= st_clean;
                reply_valid <= 1'b1;
                reply_fail  <= 1'b0;
                reply_data  <= 16'd0;
              end
              kind_status_read: begin
                fm_addr       <= fm_addr_width'(pstat_addr);
                fm_ren        <= 1'b1;
                fm_pagestatus <= 1'b1;
                state         <= st_read;
              end
              kind_flash_read, kind_flash_write: begin
                ev.ev_read_trans  <= req.kind == kind_flash_read;
                ev.ev_write_trans <= req.kind == kind_flash_write;
                fm_wd      <= req.data;
                pend_addr  <= req.word_addr;
                pend_write <= req.kind == kind_flash_write;
                if (dirty && (req_page != dirty_page)) begin
                  // Flush the dirty page before the access.
                  fm_addr    <= fm_addr_width'({dirty_page, {page_bits{1'b0}}});
                  fm_program <= 1'b1;
                  state      <= st_program;
                end else begin
                  fm_addr <= fm_addr_width'(req.word_addr);
                  fm_ren  <= req.kind == kind_flash_read;
                  fm_wen  <= req.kind == kind_flash_write;
                  state   <= (req.kind == kind_flash_write) ? st_write : st_read;
                end
              end
              default: state <= st_idle;
            endcase
          end
        end
        st_program: begin
          fm_program <= 1'b0;
          wait_cycle <= 1'b1;
          if (req.intrude)
            lb_failure <= 1'b1;
          if (done) begin
            last_status        <= {1'b0, fm_status};
            ev.ev_program      <= status_ok;
            ev.ev_program_fail <= !status_ok;
            if (status_ok)
              dirty <= 1'b0;
            // Resume the access that was held back.
            fm_addr    <= fm_addr_width'(pend_addr);
            fm_ren     <= !pend_write;
            fm_wen     <= pend_write;
            state      <= pend_write ? st_write : st_read;
            wait_cycle <= 1'b0;
          end
        end
        st_read, st_write: begin
          fm_ren        <= 1'b0;
          fm_wen        <= 1'b0;
          fm_pagestatus <= 1'b0;
          wait_cycle    <= 1'b1;
          if (req.intrude)
            lb_failure <= 1'b1;
          if (done) begin
            last_status <= {1'b0, fm_status};
            reply_valid <= 1'b1;
            reply_fail  <= lb_failure || req.intrude;
            state       <= st_clean;
            wait_cycle  <= 1'b0;
            if (state == st_read) begin
              ev.ev_read      <= status_ok;
              ev.ev_read_fail <= !status_ok;
              reply_data      <= fm_rd;
            end else begin
              ev.ev_write      <= status_ok;
              ev.ev_write_fail <= !status_ok;
              reply_data       <= 16'd0;
              if (status_ok) begin
                dirty      <= 1'b1;
                dirty_page <= fm_addr[page_bits +: page_w];
              end
            end
          end
        end
        st_clean: begin
          // Held one extra cycle behind the reply.
          reply_valid <= 1'b0;
          if (!reply_valid)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: flash_stats.sv
`default_nettype none

module flash_stats import flash_pkg::*; (
  input  wire          lb_clk,
  input  wire          hard_reset,
  flash_event_if.sink  ev,
  input  wire [2:0]    reg_sel,
  output logic [15:0]  count_value
);

  logic [counter_count-1:0] hits;
  logic [15:0]              counts [counter_count];

  always_comb begin
    hits                   = '0;
    hits[cnt_write]        = ev.ev_write;
    hits[cnt_read]         = ev.ev_read;
    hits[cnt_program]      = ev.ev_program;
    hits[cnt_write_fail]   = ev.ev_write_fail;
    hits[cnt_read_fail]    = ev.ev_read_fail;
    hits[cnt_program_fail] = ev.ev_program_fail;
    hits[cnt_read_trans]   = ev.ev_read_trans;
    hits[cnt_write_trans]  = ev.ev_write_trans;
  end

  // Counters wrap at 16 bits.
  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      for (int i = 0; i < counter_count; i++) begin
        counts[i] <= 16'd0;
      end
    end else begin
      for (int i = 0; i < counter_count; i++) begin
        if (hits[i])
          counts[i] <= counts[i] + 16'd1;
      end
    end
  end

  assign count_value = counts[reg_sel];

endmodule

`default_nettype wire

// File: lb_reply.sv
`default_nettype none

module lb_reply (
  input  wire         lb_clk,
  input  wire         hard_reset,
  input  wire         reply_valid,
  input  wire [15:0]  reply_data,
  input  wire         reply_fail,
  output logic [15:0] lb_data_out,
  output logic        lb_strb
);

  logic send;

  // A failed transaction gets no strobe.
  assign send = reply_valid && !reply_fail;

  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      lb_strb     <= 1'b0;
      lb_data_out <= 16'd0;
    end else begin
      lb_strb     <= send;
      // Data is zero outside the strobe cycle.
      lb_data_out <= send ? reply_data : 16'd0;
    end
  end

endmodule

`default_nettype wire

// File: flash_controller.sv
`default_nettype none

module flash_controller #(
  parameter int fm_addr_width = 17,
  parameter int page_bits     = 6
) (
  input  wire                      lb_clk,
  input  wire                      hard_reset,
  input  wire [15:0]               lb_addr,
  input  wire [15:0]               lb_data_in,
  input  wire                      lb_rd,
  input  wire                      lb_wr,
  output logic [15:0]              lb_data_out,
  output logic                     lb_strb,
  output logic [fm_addr_width-1:0] fm_addr,
  output logic [15:0]              fm_wd,
  output logic                     fm_ren,
  output logic                     fm_wen,
  output logic                     fm_program,
  output logic                     fm_pagestatus,
  input  wire [15:0]               fm_rd,
  input  wire                      fm_busy,
  input  wire [1:0]                fm_status
);

  logic [15:0] count_value;
  logic        reply_valid;
  logic [15:0] reply_data;
  logic        reply_fail;

  flash_req_if   req_bus ();
  flash_event_if ev_bus ();

  lb_decode i_decode (
    .lb_clk     (lb_clk),
    .hard_reset (hard_reset),
    .lb_addr    (lb_addr),
    .lb_data_in (lb_data_in),
    .lb_rd      (lb_rd),
    .lb_wr      (lb_wr),
    .fm_busy    (fm_busy),
    .req        (req_bus.decoder)
  );

  flash_sequencer #(
    .fm_addr_width (fm_addr_width),
    .page_bits     (page_bits)
  ) i_sequencer (
    .lb_clk        (lb_clk),
    .hard_reset    (hard_reset),
    .req           (req_bus.sequencer),
    .ev            (ev_bus.source),
    .count_value   (count_value),
    .fm_addr       (fm_addr),
    .fm_wd         (fm_wd),
    .fm_ren        (fm_ren),
    .fm_wen        (fm_wen),
    .fm_program    (fm_program),
    .fm_pagestatus (fm_pagestatus),
    .fm_rd         (fm_rd),
    .fm_busy       (fm_busy),
    .fm_status     (fm_status),
    .reply_valid   (reply_valid),
    .reply_data    (reply_data),
    .reply_fail    (reply_fail)
  );

  flash_stats i_stats (
    .lb_clk      (lb_clk),
    .hard_reset  (hard_reset),
    .ev          (ev_bus.sink),
    .reg_sel     (req_bus.reg_sel),
    .count_value (count_value)
  );

  lb_reply i_reply (
    .lb_clk      (lb_clk),
    .hard_reset  (hard_reset),
    .reply_valid (reply_valid),
    .reply_data  (reply_data),
    .reply_fail  (reply_fail),
    .lb_data_out (lb_data_out),
    .lb_strb     (lb_strb)
  );

endmodule

`default_nettype wire

// File: flash_checker.sv
`default_nettype none

module flash_checker import flash_pkg::*; (
  input  wire        lb_clk,
  input  wire        hard_reset,
  input  wire [15:0] lb_addr,
  input  wire [15:0] lb_data_in,
  input  wire        lb_rd,
  input  wire        lb_wr,
  input  wire [15:0] lb_data_out,
  input  wire        lb_strb,
  input  wire [16:0] fm_addr,
  input  wire [15:0] fm_wd,
  input  wire        fm_ren,
  input  wire        fm_wen,
  input  wire        fm_program,
  input  wire        fm_pagestatus,
  input  wire        dev_done,
  input  wire [1:0]  dev_status,
  output int         errors
);
  timeunit 1ns;
  timeprecision 1ns;

  localparam int page_bits = 6;

  logic [15:0] exp_mem [int];
  logic [15:0] exp_count [counter_count];
  logic        exp_dirty;
  logic [15:0] dirty_idx;
  logic [2:0]  exp_last;
  logic [15:0] exp_pstat;
  logic        op_prog;
  logic        op_write;
  logic        op_pstat;
  logic [15:0] op_addr;
  logic [15:0] op_data;
  logic        rd_known;
  logic [15:0] rd_word;
  logic        flushed;
  logic        active;
  logic        intruded;
  logic        a_rd;
  logic        a_wr;
  logic [15:0] a_addr;
  logic [15:0] a_data;
  int          a_start;
  int          cyc;
  int          quiet;

  task automatic report(input string name, input logic [15:0] exp, input logic [15:0] act);
    errors++;
    $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
  endtask

  task automatic complain(input string what);
    errors++;
    $display("%s", what);
  endtask

  function automatic logic [15:0] expected_reg(input logic [15:0] addr);
    if (addr == reg_status_a)
      return 16'(exp_last);
    if (addr == reg_dirty_page_a)
      return exp_dirty ? dirty_idx : no_dirty_page;
    return exp_count[3'(addr - reg_count_base_a)];
  endfunction

  task automatic watch_commands();
    if (fm_program) begin
      if (!exp_dirty || flushed)
        complain("FM_PROGRAM pulsed with no dirty page left to flush");
      else if (fm_addr[15:0] != (dirty_idx << page_bits))
        report("program_addr", dirty_idx << page_bits, fm_addr[15:0]);
      op_prog = 1'b1;
    end
    if (fm_ren || fm_wen) begin
      op_prog  = 1'b0;
      op_write = fm_wen;
      op_pstat = fm_pagestatus;
      op_addr  = fm_addr[15:0];
      if (fm_pagestatus) begin
        if (op_addr != exp_pstat)
          report("page_status_addr", exp_pstat, op_addr);
      end else begin
        // Flash word address follows from the bus address.
        if (fm_addr != {1'b0, a_addr - flash_window_base})
          report("flash_addr", a_addr - flash_window_base, fm_addr[15:0]);
        if (fm_wen && (fm_wd != a_data))
          report("flash_write_data", a_data, fm_wd);
        op_addr = a_addr - flash_window_base;
        op_data = a_data;
        if (exp_dirty && !flushed && ((op_addr >> page_bits) != dirty_idx))
          complain("Access to another page went ahead without a program");
        if (flushed && ((op_addr >> page_bits) == dirty_idx))
          complain("FM_PROGRAM pulsed before an access to the dirty page itself");
        flushed = 1'b0;
        if (fm_wen)
          exp_count[cnt_write_trans]++;
        else
          exp_count[cnt_read_trans]++;
      end
    end
  endtask

  task automatic finish_op();
    logic ok;
    ok       = dev_status == fm_status_ok;
    exp_last = {1'b0, dev_status};
    if (op_prog) begin
      exp_count[ok ? cnt_program : cnt_program_fail]++;
      if (ok)
        exp_dirty = 1'b0;
      flushed = 1'b1;
    end else if (op_write) begin
      exp_count[ok ? cnt_write : cnt_write_fail]++;
      if (ok) begin
        exp_mem[op_addr] = op_data;
        exp_dirty = 1'b1;
        dirty_idx = op_addr >> page_bits;
      end
      if (intruded)
        quiet = 3;
    end else begin
      exp_count[ok ? cnt_read : cnt_read_fail]++;
      rd_known = ok && !op_pstat && exp_mem.exists(op_addr);
      if (rd_known)
        rd_word = exp_mem[op_addr];
    end
  endtask

  task automatic check_reply();
    logic is_reg;
    is_reg = (a_addr < flash_window_base) && (a_addr != reg_page_status_a);
    if (a_rd && (a_addr >= flash_window_base)) begin
      if (rd_known && (lb_data_out != rd_word))
        report("flash_read", rd_word, lb_data_out);
    end else if (a_rd && is_reg) begin
      if (lb_data_out != expected_reg(a_addr))
        report(a_addr >= reg_count_base_a ? "counter" : "register_read",
               expected_reg(a_addr), lb_data_out);
    end else if (a_wr) begin
      if (a_addr == reg_page_status_a)
        exp_pstat = lb_data_in;
      if (lb_data_out != 16'd0)
        report("write_reply", 16'd0, lb_data_out);
    end
    // Strobe driven in cycle 2 is seen at the edge of cycle 3.
    if (is_reg && (cyc - a_start != 3))
      report("strobe_latency", 16'd3, 16'(cyc - a_start));
  endtask

  always @(posedge lb_clk) begin
    if (hard_reset) begin
      errors    = 0;
      exp_mem.delete();
      for (int i = 0; i < counter_count; i++) begin
        exp_count[i] = 16'd0;
      end
      exp_dirty = 1'b0;
      dirty_idx = 16'd0;
      exp_last  = 3'b111;
      exp_pstat = 16'd0;
      op_prog   = 1'b0;
      op_write  = 1'b0;
      op_pstat  = 1'b0;
      rd_known  = 1'b0;
      flushed   = 1'b0;
      active    = 1'b0;
      intruded  = 1'b0;
      quiet     = 0;
      cyc       = 0;
    end else begin
      cyc++;
      if (!active && !intruded && (lb_rd || lb_wr)) begin
        active  = 1'b1;
        a_rd    = lb_rd;
        a_wr    = lb_wr;
        a_addr  = lb_addr;
        a_data  = lb_data_in;
        a_start = cyc;
      end else if (active && (lb_rd || lb_wr) &&
                   ((lb_rd != a_rd) || (lb_wr != a_wr) || (lb_addr != a_addr)))
        intruded = 1'b1;
      watch_commands();
      if (dev_done)
        finish_op();
      if (lb_strb) begin
        if (intruded)
          complain("Strobe came back on a transaction that was broken into");
        else if (!active)
          complain("Strobe seen with no bus access running");
        else
          check_reply();
        active = 1'b0;
      end
      if (quiet > 0) begin
        quiet--;
        if (quiet == 0) begin
          intruded = 1'b0;
          active   = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_flash_controller.sv
`default_nettype none

module tb_flash_controller import flash_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int n_trans     = 200;
  localparam int cycle_limit = n_trans * 20 + 500;

  logic        lb_clk;
  logic        hard_reset;
  logic [15:0] lb_addr;
  logic [15:0] lb_data_in;
  logic        lb_rd;
  logic        lb_wr;
  logic [15:0] lb_data_out;
  logic        lb_strb;
  logic [16:0] fm_addr;
  logic [15:0] fm_wd;
  logic        fm_ren;
  logic        fm_wen;
  logic        fm_program;
  logic        fm_pagestatus;
  logic [15:0] fm_rd;
  logic        fm_busy;
  logic [1:0]  fm_status;

  logic [31:0] lfsr;
  logic [15:0] mem [0:65535];
  int          busy_left;
  logic        op_write;
  logic        op_pstat;
  logic [15:0] op_addr;
  logic [15:0] op_data;
  logic        dev_done;
  int          errors;
  int          cycles;

  flash_controller #(
    .fm_addr_width (17),
    .page_bits     (6)
  ) i_dut (
    .lb_clk        (lb_clk),
    .hard_reset    (hard_reset),
    .lb_addr       (lb_addr),
    .lb_data_in    (lb_data_in),
    .lb_rd         (lb_rd),
    .lb_wr         (lb_wr),
    .lb_data_out   (lb_data_out),
    .lb_strb       (lb_strb),
    .fm_addr       (fm_addr),
    .fm_wd         (fm_wd),
    .fm_ren        (fm_ren),
    .fm_wen        (fm_wen),
    .fm_program    (fm_program),
    .fm_pagestatus (fm_pagestatus),
    .fm_rd         (fm_rd),
    .fm_busy       (fm_busy),
    .fm_status     (fm_status)
  );

  flash_checker i_check (
    .lb_clk        (lb_clk),
    .hard_reset    (hard_reset),
    .lb_addr       (lb_addr),
    .lb_data_in    (lb_data_in),
    .lb_rd         (lb_rd),
    .lb_wr         (lb_wr),
    .lb_data_out   (lb_data_out),
    .lb_strb       (lb_strb),
    .fm_addr       (fm_addr),
    .fm_wd         (fm_wd),
    .fm_ren        (fm_ren),
    .fm_wen        (fm_wen),
    .fm_program    (fm_program),
    .fm_pagestatus (fm_pagestatus),
    .dev_done      (dev_done),
    .dev_status    (fm_status),
    .errors        (errors)
  );

  always #50 lb_clk = ~lb_clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = 16'd0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // One word in one of four pages, as a bus address.
  function automatic logic [15:0] flash_addr();
    logic [15:0] page;
    page = take_bits(2) * 16'd21;
    return flash_window_base + ((page << 6) | take_bits(6));
  endfunction

  // Flash device model.
  always @(negedge lb_clk) begin
    dev_done = 1'b0;
    if (hard_reset) begin
      fm_busy   = 1'b0;
      busy_left = 0;
    end else if (fm_ren || fm_wen || fm_program) begin
      op_write  = fm_wen;
      op_pstat  = fm_pagestatus;
      op_addr   = fm_addr[15:0];
      op_data   = fm_wd;
      fm_busy   = 1'b1;
      busy_left = int'(take_bits(2)) + 1;
    end else if (busy_left > 0) begin
      busy_left--;
      if (busy_left == 0) begin
        fm_status = (take_bits(4) == 16'd0) ? 2'b01 : fm_status_ok;
        fm_rd     = 16'hdead;
        if (fm_status == fm_status_ok) begin
          if (op_write)
            mem[op_addr] = op_data;
          else
            fm_rd = op_pstat ? (op_addr ^ 16'h00ff) : mem[op_addr];
        end
        fm_busy  = 1'b0;
        dev_done = 1'b1;
      end
    end
  end

  always @(posedge lb_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // Called on a falling edge, returns on one.
  task automatic bus_access(input logic write, input logic [15:0] addr, input logic [15:0] data);
    lb_addr    = addr;
    lb_data_in = data;
    lb_rd      = !write;
    lb_wr      = write;
    do @(negedge lb_clk); while (!lb_strb);
    lb_rd = 1'b0;
    lb_wr = 1'b0;
    @(negedge lb_clk);
  endtask

  // A read breaks into a running flash write.
  task automatic intrude_on_write();
    logic [15:0] rd_addr;
    lb_addr    = flash_addr();
    lb_data_in = take_bits(16);
    rd_addr    = flash_addr();
    lb_wr      = 1'b1;
    repeat (2) @(negedge lb_clk);
    lb_wr   = 1'b0;
    lb_rd   = 1'b1;
    lb_addr = rd_addr;
    @(negedge lb_clk);
    lb_rd = 1'b0;
    do @(posedge lb_clk); while (!(dev_done && op_write));
    repeat (4) @(negedge lb_clk);
  endtask

  initial begin
    logic [15:0] sel;
    lb_clk     = 1'b0;
    hard_reset = 1'b1;
    lb_addr    = 16'd0;
    lb_data_in = 16'd0;
    lb_rd      = 1'b0;
    lb_wr      = 1'b0;
    fm_rd      = 16'd0;
    fm_busy    = 1'b0;
    fm_status  = fm_status_ok;
    dev_done   = 1'b0;
    busy_left  = 0;
    cycles     = 0;
    lfsr       = 32'hfecb6f29;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i * 7) ^ {i[7:0], i[15:8]};
    end
    repeat (3) @(negedge lb_clk);
    hard_reset = 1'b0;
    @(negedge lb_clk);
    for (int i = 0; i < n_trans; i++) begin
      sel = take_bits(4);
      if (i == n_trans / 2)
        intrude_on_write();
      if (sel == 0) begin
        bus_access(1'b1, reg_page_status_a, flash_addr() - flash_window_base);
        bus_access(1'b0, reg_page_status_a, 16'd0);
      end else if (sel == 1)
        bus_access(1'b0, take_bits(1) ? reg_status_a : reg_dirty_page_a, 16'd0);
      else if (sel < 9)
        bus_access(1'b1, flash_addr(), take_bits(16));
      else
        bus_access(1'b0, flash_addr(), 16'd0);
    end
    bus_access(1'b0, reg_status_a, 16'd0);
    bus_access(1'b0, reg_dirty_page_a, 16'd0);
    for (int i = 0; i < counter_count; i++) begin
      bus_access(1'b0, reg_count_base_a + 16'(i), 16'd0);
    end
    $display("Error count: %0d", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
flash_pkg.sv
flash_ifs.sv
lb_decode.sv
flash_sequencer.sv
flash_stats.sv
lb_reply.sv
flash_controller.sv
flash_checker.sv
tb_flash_controller.sv

// File: Bender.yml
package:
  name: flash_controller

sources:
  - flash_pkg.sv
  - flash_ifs.sv
  - lb_decode.sv
  - flash_sequencer.sv
  - flash_stats.sv
  - lb_reply.sv
  - flash_controller.sv
  - target: test
    files:
      - flash_checker.sv
      - tb_flash_controller.sv
